/* source/cachePkg.sv */
package cachePkg;

    // geometry of words, lines and the two caches
    localparam int WORD_SIZE      = 32;
    localparam int ADDR_SIZE      = 12;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_SIZE      = WORD_SIZE * WORDS_PER_LINE;
    localparam int NUM_LINES      = 8;
    localparam int INDEX_SIZE     = 3;
    localparam int OFFSET_SIZE    = 2;
    localparam int BYTE_SIZE      = 2;
    localparam int TAG_SIZE       = ADDR_SIZE - INDEX_SIZE - OFFSET_SIZE - BYTE_SIZE;
    localparam int LINE_ADDR_SIZE = TAG_SIZE + INDEX_SIZE;
    localparam int WORD_ADDR_SIZE = ADDR_SIZE - BYTE_SIZE;
    localparam int NUM_MEM_LINES  = 2 ** LINE_ADDR_SIZE;

    // memory timing, cycles from grant to ready
    localparam int MEM_LATENCY      = 3;
    localparam int LATENCY_CNT_SIZE = $clog2(MEM_LATENCY + 1);

    localparam logic [WORD_SIZE-1:0] FILL_KEY = 32'h5a3c_96e1;

    // cache controller states
    localparam logic [1:0] STATE_IDLE       = 2'd0;
    localparam logic [1:0] STATE_WRITE_BACK = 2'd1;
    localparam logic [1:0] STATE_REFILL     = 2'd2;
    localparam logic [1:0] STATE_FINISH     = 2'd3;

    // bus owner encodings
    localparam logic [1:0] OWNER_NONE  = 2'd0;
    localparam logic [1:0] OWNER_DATA  = 2'd1;
    localparam logic [1:0] OWNER_INSTR = 2'd2;

    // one byte address, seen whole or split into cache fields
    typedef union packed {
        logic [ADDR_SIZE-1:0] raw;
        struct packed {
            logic [TAG_SIZE-1:0]    tag;
            logic [INDEX_SIZE-1:0]  index;
            logic [OFFSET_SIZE-1:0] offset;
            logic [BYTE_SIZE-1:0]   byteSel;
        } fields;
    } byteAddr;

    // power-up content of one memory word
    function automatic logic [WORD_SIZE-1:0] fillWord(input logic [WORD_ADDR_SIZE-1:0] wordAddr);
        return {{(WORD_SIZE - WORD_ADDR_SIZE){1'b0}}, wordAddr} ^ FILL_KEY;
    endfunction

endpackage

/* source/dataCache.sv */
`timescale 1ns/1ps

module dataCache
    import cachePkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      readEnable,
    input  logic                      writeEnable,
    input  logic                      byteLoad,
    input  byteAddr                   address,
    input  logic [WORD_SIZE-1:0]      writeData,
    input  logic                      memReady,
    input  logic [LINE_SIZE-1:0]      memLine,
    output logic [WORD_SIZE-1:0]      value,
    output logic                      loadDone,
    output logic                      storeDone,
    output logic                      stall,
    output logic                      memRead,
    output logic                      memWrite,
    output logic [LINE_ADDR_SIZE-1:0] lineAddr,
    output logic [LINE_SIZE-1:0]      writeLine
);

    logic [LINE_SIZE-1:0]  dataArray [NUM_LINES];
    logic [TAG_SIZE-1:0]   tagArray  [NUM_LINES];
    logic [NUM_LINES-1:0]  validBits;
    logic [NUM_LINES-1:0]  dirtyBits;
    logic [1:0]            state;
    logic                  hitDone;

    // request captured when the strobe is accepted
    byteAddr               reqAddr;
    logic [WORD_SIZE-1:0]  reqData;
    logic                  reqStore;
    logic                  reqByte;

    logic [INDEX_SIZE-1:0] addrIndex;
    logic [INDEX_SIZE-1:0] reqIndex;
    logic                  accept;
    logic                  hit;
    logic [LINE_SIZE-1:0]  refillLine;
    logic [LINE_SIZE-1:0]  curLine;
    logic [WORD_SIZE-1:0]  curWord;

    assign addrIndex = address.fields.index;
    assign reqIndex  = reqAddr.fields.index;

    // finish behaves like idle, so a new strobe can follow the done pulse
    assign accept = (state == STATE_IDLE || state == STATE_FINISH) && (readEnable || writeEnable);
    assign hit    = validBits[addrIndex] && (tagArray[addrIndex] == address.fields.tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= STATE_IDLE;
            hitDone   <= 1'b0;
            validBits <= '0;
            dirtyBits <= '0;
        end else begin
            hitDone <= 1'b0;
            case (state)
                STATE_IDLE, STATE_FINISH: begin
                    state <= STATE_IDLE;
                    if (accept) begin
                        if (hit) begin
                            hitDone <= 1'b1;
                            if (writeEnable) begin
                                dirtyBits[addrIndex] <= 1'b1;
                            end
                        end else if (validBits[addrIndex] && dirtyBits[addrIndex]) begin
                            state <= STATE_WRITE_BACK;
                        end else begin
                            state <= STATE_REFILL;
                        end
                    end
                end
                STATE_WRITE_BACK: begin
                    // victim is in memory now, go fetch the new line
                    if (memReady) begin
                        state <= STATE_REFILL;
                    end
                end
                STATE_REFILL: begin
                    if (memReady) begin
                        validBits[reqIndex] <= 1'b1;
                        dirtyBits[reqIndex] <= reqStore;
                        state               <= STATE_FINISH;
                    end
                end
                default: state <= STATE_IDLE;
            endcase
        end
    end

    // store miss merges its word into the incoming line
    always_comb begin
        refillLine = memLine;
        if (reqStore) begin
            refillLine[reqAddr.fields.offset * WORD_SIZE +: WORD_SIZE] = reqData;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reqAddr  <= address;
            reqData  <= writeData;
            reqStore <= writeEnable;
            reqByte  <= byteLoad;
            if (hit && writeEnable) begin
                dataArray[addrIndex][address.fields.offset * WORD_SIZE +: WORD_SIZE] <= writeData;
            end
        end
        if (state == STATE_REFILL && memReady) begin
            dataArray[reqIndex] <= refillLine;
            tagArray[reqIndex]  <= reqAddr.fields.tag;
        end
    end

    // load result comes straight from the array, valid with the done pulse
    assign curLine = dataArray[reqIndex];
    assign curWord = curLine[reqAddr.fields.offset * WORD_SIZE +: WORD_SIZE];
    assign value   = reqByte ? {{(WORD_SIZE - 8){1'b0}}, curWord[reqAddr.fields.byteSel * 8 +: 8]}
                             : curWord;

    assign loadDone  = (hitDone || state == STATE_FINISH) && !reqStore;
    assign storeDone = (hitDone || state == STATE_FINISH) && reqStore;
    assign stall     = (state == STATE_WRITE_BACK) || (state == STATE_REFILL);

    // bus side, held steady until the arbiter hands back ready
    assign memWrite  = (state == STATE_WRITE_BACK);
    assign memRead   = (state == STATE_REFILL);
    assign lineAddr  = memWrite ? {tagArray[reqIndex], reqIndex}
                                : {reqAddr.fields.tag, reqIndex};
    assign writeLine = dataArray[reqIndex];

endmodule

/* source/instrCache.sv */
`timescale 1ns/1ps

module instrCache
    import cachePkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetchEnable,
    input  byteAddr                   address,
    input  logic                      memReady,
    input  logic [LINE_SIZE-1:0]      memLine,
    output logic [WORD_SIZE-1:0]      instr,
    output logic                      fetchDone,
    output logic                      stall,
    output logic                      memRead,
    output logic [LINE_ADDR_SIZE-1:0] lineAddr
);

    logic [LINE_SIZE-1:0]  dataArray [NUM_LINES];
    logic [TAG_SIZE-1:0]   tagArray  [NUM_LINES];
    logic [NUM_LINES-1:0]  validBits;
    logic [1:0]            state;
    logic                  hitDone;
    byteAddr               reqAddr;
    logic [INDEX_SIZE-1:0] addrIndex;
    logic [INDEX_SIZE-1:0] reqIndex;
    logic                  accept;
    logic                  hit;
    logic [LINE_SIZE-1:0]  curLine;

    assign addrIndex = address.fields.index;
    assign reqIndex  = reqAddr.fields.index;
    assign accept    = (state == STATE_IDLE || state == STATE_FINISH) && fetchEnable;
    assign hit       = validBits[addrIndex] && (tagArray[addrIndex] == address.fields.tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= STATE_IDLE;
            hitDone   <= 1'b0;
            validBits <= '0;
        end else begin
            hitDone <= 1'b0;
            case (state)
                STATE_IDLE, STATE_FINISH: begin
                    state <= STATE_IDLE;
                    if (accept) begin
                        if (hit) begin
                            hitDone <= 1'b1;
                        end else begin
                            state <= STATE_REFILL;
                        end
                    end
                end
                STATE_REFILL: begin
                    if (memReady) begin
                        validBits[reqIndex] <= 1'b1;
                        state               <= STATE_FINISH;
                    end
                end
                default: state <= STATE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reqAddr <= address;
        end
        if (state == STATE_REFILL && memReady) begin
            dataArray[reqIndex] <= memLine;
            tagArray[reqIndex]  <= reqAddr.fields.tag;
        end
    end

    assign curLine   = dataArray[reqIndex];
    assign instr     = curLine[reqAddr.fields.offset * WORD_SIZE +: WORD_SIZE];
    assign fetchDone = hitDone || (state == STATE_FINISH);
    assign stall     = (state == STATE_REFILL);
    assign memRead   = (state == STATE_REFILL);
    assign lineAddr  = {reqAddr.fields.tag, reqIndex};

endmodule

/* source/memArbiter.sv */
`timescale 1ns/1ps

module memArbiter
    import cachePkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dRead,
    input  logic                      dWrite,
    input  logic [LINE_ADDR_SIZE-1:0] dLineAddr,
    input  logic [LINE_SIZE-1:0]      dWriteLine,
    input  logic                      iRead,
    input  logic [LINE_ADDR_SIZE-1:0] iLineAddr,
    input  logic                      memReadyIn,
    input  logic [LINE_SIZE-1:0]      memLineIn,
    output logic                      memRead,
    output logic                      memWrite,
    output logic [LINE_ADDR_SIZE-1:0] memLineAddr,
    output logic [LINE_SIZE-1:0]      memWriteLine,
    output logic                      dReady,
    output logic                      iReady,
    output logic [LINE_SIZE-1:0]      dLine,
    output logic [LINE_SIZE-1:0]      iLine
);

    logic [1:0] owner;

    // a new owner is chosen only from idle, data side first
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWNER_NONE;
        end else if (owner == OWNER_NONE) begin
            if (dRead || dWrite) begin
                owner <= OWNER_DATA;
            end else if (iRead) begin
                owner <= OWNER_INSTR;
            end
        end else if (memReadyIn) begin
            // transfer done, bus is free again next cycle
            owner <= OWNER_NONE;
        end
    end

    always_comb begin
        memRead      = 1'b0;
        memWrite     = 1'b0;
        memLineAddr  = dLineAddr;
        memWriteLine = dWriteLine;
        case (owner)
            OWNER_DATA: begin
                memRead  = dRead;
                memWrite = dWrite;
            end
            OWNER_INSTR: begin
                memRead     = iRead;
                memLineAddr = iLineAddr;
            end
            default: ;
        endcase
    end

    // return path goes only to the owner
    assign dReady = (owner == OWNER_DATA) && memReadyIn;
    assign iReady = (owner == OWNER_INSTR) && memReadyIn;
    assign dLine  = (owner == OWNER_DATA) ? memLineIn : '0;
    assign iLine  = (owner == OWNER_INSTR) ? memLineIn : '0;

endmodule

/* source/lineMemory.sv */
`timescale 1ns/1ps

module lineMemory
    import cachePkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      memRead,
    input  logic                      memWrite,
    input  logic [LINE_ADDR_SIZE-1:0] memLineAddr,
    input  logic [LINE_SIZE-1:0]      memWriteLine,
    output logic                      memReady,
    output logic [LINE_SIZE-1:0]      memLine
);

    logic [LINE_SIZE-1:0]        lines [NUM_MEM_LINES];
    logic                        busy;
    logic [LATENCY_CNT_SIZE-1:0] count;

    // each word starts out as its own word address mixed with the key
    initial begin
        for (int l = 0; l < NUM_MEM_LINES; l++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                lines[l][w * WORD_SIZE +: WORD_SIZE] =
                    fillWord({LINE_ADDR_SIZE'(l), OFFSET_SIZE'(w)});
            end
        end
    end

    // the request stays up through the ready cycle, so don't restart on it
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            count    <= '0;
            memReady <= 1'b0;
        end else begin
            memReady <= 1'b0;
            if (busy) begin
                count <= count - 1'b1;
                if (count == LATENCY_CNT_SIZE'(1)) begin
                    memReady <= 1'b1;
                    busy     <= 1'b0;
                end
            end else if ((memRead || memWrite) && !memReady) begin
                busy  <= 1'b1;
                count <= LATENCY_CNT_SIZE'(MEM_LATENCY - 1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy && count == LATENCY_CNT_SIZE'(1)) begin
            memLine <= lines[memLineAddr];
        end
        // address and line are still held by the requester here
        if (memReady && memWrite) begin
            lines[memLineAddr] <= memWriteLine;
        end
    end

endmodule

/* source/memSubsystem.sv */
`timescale 1ns/1ps

module memSubsystem
    import cachePkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dReadEnable,
    input  logic                 dWriteEnable,
    input  logic                 dByteLoad,
    input  byteAddr              dAddress,
    input  logic [WORD_SIZE-1:0] dWriteData,
    output logic [WORD_SIZE-1:0] dValue,
    output logic                 dLoadDone,
    output logic                 dStoreDone,
    output logic                 dStall,
    input  logic                 iFetchEnable,
    input  byteAddr              iAddress,
    output logic [WORD_SIZE-1:0] iInstr,
    output logic                 iFetchDone,
    output logic                 iStall
);

    // data cache to arbiter
    logic                      dMemRead;
    logic                      dMemWrite;
    logic [LINE_ADDR_SIZE-1:0] dLineAddr;
    logic [LINE_SIZE-1:0]      dWriteLine;
    logic                      dMemReady;
    logic [LINE_SIZE-1:0]      dMemLine;

    // instruction cache to arbiter
    logic                      iMemRead;
    logic [LINE_ADDR_SIZE-1:0] iLineAddr;
    logic                      iMemReady;
    logic [LINE_SIZE-1:0]      iMemLine;

    // arbiter to memory
    logic                      memRead;
    logic                      memWrite;
    logic [LINE_ADDR_SIZE-1:0] memLineAddr;
    logic [LINE_SIZE-1:0]      memWriteLine;
    logic                      memReady;
    logic [LINE_SIZE-1:0]      memLine;

    dataCache dCache (
        .clk(clk), .rst(rst),
        .readEnable(dReadEnable), .writeEnable(dWriteEnable), .byteLoad(dByteLoad),
        .address(dAddress), .writeData(dWriteData),
        .memReady(dMemReady), .memLine(dMemLine),
        .value(dValue), .loadDone(dLoadDone), .storeDone(dStoreDone), .stall(dStall),
        .memRead(dMemRead), .memWrite(dMemWrite), .lineAddr(dLineAddr), .writeLine(dWriteLine)
    );

    instrCache iCache (
        .clk(clk), .rst(rst),
        .fetchEnable(iFetchEnable), .address(iAddress),
        .memReady(iMemReady), .memLine(iMemLine),
        .instr(iInstr), .fetchDone(iFetchDone), .stall(iStall),
        .memRead(iMemRead), .lineAddr(iLineAddr)
    );

    memArbiter arbiter (
        .clk(clk), .rst(rst),
        .dRead(dMemRead), .dWrite(dMemWrite), .dLineAddr(dLineAddr), .dWriteLine(dWriteLine),
        .iRead(iMemRead), .iLineAddr(iLineAddr),
        .memReadyIn(memReady), .memLineIn(memLine),
        .memRead(memRead), .memWrite(memWrite),
        .memLineAddr(memLineAddr), .memWriteLine(memWriteLine),
        .dReady(dMemReady), .iReady(iMemReady), .dLine(dMemLine), .iLine(iMemLine)
    );

    lineMemory memory (
        .clk(clk), .rst(rst),
        .memRead(memRead), .memWrite(memWrite),
        .memLineAddr(memLineAddr), .memWriteLine(memWriteLine),
        .memReady(memReady), .memLine(memLine)
    );

endmodule

/* sim/memSubsystemProps.sv */
`timescale 1ns/1ps

module memSubsystemProps (
    input logic clk,
    input logic rst,
    input logic dRead,
    input logic dWrite,
    input logic iRead,
    input logic memRead,
    input logic memWrite,
    input logic memReadyIn,
    input logic dReady,
    input logic iReady
);

    // number of assertion failures so far
    int failures = 0;

    busDirection: assert property (@(posedge clk) disable iff (rst) !(memRead && memWrite))
        else begin
            $error("memory read and write are high together");
            failures++;
        end

    // each memory ready goes to exactly one cache
    readyExclusive: assert property (@(posedge clk) disable iff (rst)
        memReadyIn |-> (dReady ^ iReady))
        else begin
            $error("memory ready did not reach exactly one cache");
            failures++;
        end

    // a cache only sees ready while it still holds its request
    readyToRequester: assert property (@(posedge clk) disable iff (rst)
        (!dReady || dRead || dWrite) && (!iReady || iRead))
        else begin
            $error("ready pulse went to a cache that is not requesting");
            failures++;
        end

    // the cache stall equals its bus request, so this covers stall as well
    quietAfterReset: assert property (@(posedge clk) $fell(rst) |-> !(dRead || dWrite || iRead))
        else begin
            $error("stall or memory request high right after reset");
            failures++;
        end

endmodule

bind memArbiter memSubsystemProps props (.*);

/* sim/memSubsystemChecker.sv */
`timescale 1ns/1ps

module memSubsystemChecker
    import cachePkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dReadEnable,
    input  logic                 dWriteEnable,
    input  logic                 dByteLoad,
    input  byteAddr              dAddress,
    input  logic [WORD_SIZE-1:0] dWriteData,
    input  logic [WORD_SIZE-1:0] dValue,
    input  logic                 dLoadDone,
    input  logic                 dStoreDone,
    input  logic                 dStall,
    input  logic                 iFetchEnable,
    input  byteAddr              iAddress,
    input  logic [WORD_SIZE-1:0] iInstr,
    input  logic                 iFetchDone,
    input  logic                 iStall,
    output int                   errors,
    output int                   dataChecks,
    output int                   fetchChecks
);

    // stored words override the power-up value of their address
    logic [WORD_SIZE-1:0]      model   [2 ** WORD_ADDR_SIZE];
    bit                        written [2 ** WORD_ADDR_SIZE];
    int                        errCount   = 0;
    int                        dataCount  = 0;
    int                        fetchCount = 0;
    bit                        afterReset = 1'b0;
    bit                        dataPending  = 1'b0;
    bit                        dataStore    = 1'b0;
    bit                        fetchPending = 1'b0;
    logic [WORD_SIZE-1:0]      dataExpect;
    logic [WORD_SIZE-1:0]      fetchExpect;
    string                     dataName;
    byteAddr                   a;
    logic [WORD_ADDR_SIZE-1:0] idx;
    logic [WORD_SIZE-1:0]      word;

    assign errors      = errCount;
    assign dataChecks  = dataCount;
    assign fetchChecks = fetchCount;

    function automatic logic [WORD_ADDR_SIZE-1:0] wordIndex(input byteAddr addr);
        return {addr.fields.tag, addr.fields.index, addr.fields.offset};
    endfunction

    function automatic logic [WORD_SIZE-1:0] modelWord(input logic [WORD_ADDR_SIZE-1:0] i);
        if (written[i]) begin
            return model[i];
        end
        return {{(WORD_SIZE - WORD_ADDR_SIZE){1'b0}}, i} ^ FILL_KEY;
    endfunction

    task automatic compareWord(input string name, input logic [WORD_SIZE-1:0] expected,
                               input logic [WORD_SIZE-1:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
            errCount++;
        end
    endtask

    task automatic reportProblem(input string msg);
        $display("error at %0t: %s", $time, msg);
        errCount++;
    endtask

    always @(posedge clk) begin
        if ((rst || afterReset) && (dLoadDone || dStoreDone || iFetchDone || dStall || iStall)) begin
            reportProblem("done pulse or stall seen during or right after reset");
        end
        afterReset = rst;
        if (!rst) begin
            // completion of the outstanding data request
            if (dLoadDone || dStoreDone) begin
                dataCount++;
                if (!dataPending) begin
                    reportProblem("data done pulse with no request outstanding");
                end else if (dLoadDone && dStoreDone) begin
                    reportProblem("load and store done pulses came together");
                end else if (dataStore && !dStoreDone) begin
                    reportProblem("store ended with a load done pulse");
                end else if (!dataStore && !dLoadDone) begin
                    reportProblem("load ended with a store done pulse");
                end else if (!dataStore) begin
                    compareWord(dataName, dataExpect, dValue);
                end
                dataPending = 1'b0;
            end
            if (dReadEnable || dWriteEnable) begin
                a           = dAddress;
                idx         = wordIndex(a);
                dataPending = 1'b1;
                dataStore   = dWriteEnable;
                if (dWriteEnable) begin
                    model[idx]   = dWriteData;
                    written[idx] = 1'b1;
                end else begin
                    word = modelWord(idx);
                    if (dByteLoad) begin
                        dataExpect = {{(WORD_SIZE - 8){1'b0}}, word[a.fields.byteSel * 8 +: 8]};
                        dataName   = "byte load";
                    end else begin
                        dataExpect = word;
                        dataName   = "word load";
                    end
                end
            end
            if (iFetchDone) begin
                fetchCount++;
                if (!fetchPending) begin
                    reportProblem("fetch done pulse with no fetch outstanding");
                end else begin
                    compareWord("fetch", fetchExpect, iInstr);
                end
                fetchPending = 1'b0;
            end
            if (iFetchEnable) begin
                fetchPending = 1'b1;
                fetchExpect  = modelWord(wordIndex(iAddress));
            end
        end
    end

endmodule

/* sim/memSubsystemTb.sv */
`timescale 1ns/1ps

module memSubsystemTb
    import cachePkg::*;
();

    localparam int NUM_OPS     = 400;
    localparam int CLK_PERIOD  = 100;
    // a dirty miss needs a write and a read transfer that may each wait behind the other side
    localparam int MISS_CYCLES = 4 * (MEM_LATENCY + 2);
    localparam int TIMEOUT_NS  = 2 * (2 * NUM_OPS) * MISS_CYCLES * CLK_PERIOD;
    localparam logic [31:0] SEED = 32'h1ed7;

    logic                 clk;
    logic                 rst;
    logic                 dReadEnable;
    logic                 dWriteEnable;
    logic                 dByteLoad;
    byteAddr              dAddress;
    logic [WORD_SIZE-1:0] dWriteData;
    logic [WORD_SIZE-1:0] dValue;
    logic                 dLoadDone;
    logic                 dStoreDone;
    logic                 dStall;
    logic                 iFetchEnable;
    byteAddr              iAddress;
    logic [WORD_SIZE-1:0] iInstr;
    logic                 iFetchDone;
    logic                 iStall;
    int                   errors;
    int                   dataChecks;
    int                   fetchChecks;

    memSubsystem dut (
        .clk(clk), .rst(rst),
        .dReadEnable(dReadEnable), .dWriteEnable(dWriteEnable), .dByteLoad(dByteLoad),
        .dAddress(dAddress), .dWriteData(dWriteData), .dValue(dValue),
        .dLoadDone(dLoadDone), .dStoreDone(dStoreDone), .dStall(dStall),
        .iFetchEnable(iFetchEnable), .iAddress(iAddress), .iInstr(iInstr),
        .iFetchDone(iFetchDone), .iStall(iStall)
    );

    memSubsystemChecker resultCheck (
        .clk(clk), .rst(rst),
        .dReadEnable(dReadEnable), .dWriteEnable(dWriteEnable), .dByteLoad(dByteLoad),
        .dAddress(dAddress), .dWriteData(dWriteData), .dValue(dValue),
        .dLoadDone(dLoadDone), .dStoreDone(dStoreDone), .dStall(dStall),
        .iFetchEnable(iFetchEnable), .iAddress(iAddress), .iInstr(iInstr),
        .iFetchDone(iFetchDone), .iStall(iStall),
        .errors(errors), .dataChecks(dataChecks), .fetchChecks(fetchChecks)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeBits(inout logic [31:0] s, input int n, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            s    = lfsrStep(s);
            bits = {bits[30:0], s[0]};
        end
    endtask

    // tags 0..3 in the lower half give each index conflicts and dirty evictions
    task automatic loadStoreTraffic();
        logic [31:0] s;
        logic [31:0] bits;
        logic [31:0] wdata;
        logic [1:0]  kind;
        byteAddr     a;
        s = SEED;
        for (int n = 0; n < NUM_OPS; n++) begin
            while (dStall) @(posedge clk);
            takeBits(s, 2, bits);
            kind  = bits[1:0];
            a.raw = '0;
            takeBits(s, 2, bits);
            a.fields.tag = TAG_SIZE'(bits[1:0]);
            takeBits(s, INDEX_SIZE, bits);
            a.fields.index = bits[INDEX_SIZE-1:0];
            takeBits(s, OFFSET_SIZE, bits);
            a.fields.offset = bits[OFFSET_SIZE-1:0];
            if (kind == 2'd0) begin
                takeBits(s, BYTE_SIZE, bits);
                a.fields.byteSel = bits[BYTE_SIZE-1:0];
            end
            wdata = '0;
            if (kind[1]) begin
                takeBits(s, 32, wdata);
            end
            dAddress     <= a;
            dWriteData   <= wdata;
            dByteLoad    <= (kind == 2'd0);
            dReadEnable  <= !kind[1];
            dWriteEnable <= kind[1];
            @(posedge clk);
            dReadEnable  <= 1'b0;
            dWriteEnable <= 1'b0;
            while (!(dLoadDone || dStoreDone)) @(posedge clk);
        end
    endtask

    // fetches stay in the upper half that the data side never writes
    task automatic fetchTraffic();
        logic [31:0] s;
        logic [31:0] bits;
        byteAddr     a;
        s = SEED;
        for (int n = 0; n < NUM_OPS; n++) begin
            while (iStall) @(posedge clk);
            a.raw = '0;
            takeBits(s, TAG_SIZE - 1, bits);
            a.fields.tag = {1'b1, bits[TAG_SIZE-2:0]};
            takeBits(s, INDEX_SIZE, bits);
            a.fields.index = bits[INDEX_SIZE-1:0];
            takeBits(s, OFFSET_SIZE, bits);
            a.fields.offset = bits[OFFSET_SIZE-1:0];
            iAddress     <= a;
            iFetchEnable <= 1'b1;
            @(posedge clk);
            iFetchEnable <= 1'b0;
            while (!iFetchDone) @(posedge clk);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the operations did not all finish within %0d ns", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int assertFails;
        clk          = 1'b0;
        rst          <= 1'b1;
        dReadEnable  <= 1'b0;
        dWriteEnable <= 1'b0;
        dByteLoad    <= 1'b0;
        dAddress     <= '0;
        dWriteData   <= '0;
        iFetchEnable <= 1'b0;
        iAddress     <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        fork
            loadStoreTraffic();
            fetchTraffic();
        join
        repeat (4) @(posedge clk);
        assertFails = dut.arbiter.props.failures;
        $display("done: %0d data checks, %0d fetch checks, %0d errors, %0d assertion failures",
                 dataChecks, fetchChecks, errors, assertFails);
        if (errors + assertFails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* memSubsystem.f */
source/cachePkg.sv
source/dataCache.sv
source/instrCache.sv
source/memArbiter.sv
source/lineMemory.sv
source/memSubsystem.sv
sim/memSubsystemProps.sv
sim/memSubsystemChecker.sv
sim/memSubsystemTb.sv

/* run.sh */
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module memSubsystemTb \
    -f memSubsystem.f -o memSubsystemSim > build.log 2>&1 \
    && ./obj_dir/memSubsystemSim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && echo "simulation failed, see sim.log and build.log" && exit 1
echo "simulation passed"
